// ==== source/spi_master_pkg.sv ====
/*
  Shared types of the SPI master pipeline.
  A command word carries at most BYTES_PER_WORD bytes, sent MSB first.
*/

package spi_master_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int BYTES_PER_WORD = 4;  // bytes in one command word

  ////////////////////////////////////////////////////////////
  // data types
  ////////////////////////////////////////////////////////////

  typedef logic [8*BYTES_PER_WORD-1:0] word_t;  // command / response word
  typedef logic [7:0] byte_t;                   // one serial byte

  // byte count minus one, 0 -> 1 byte, 3 -> 4 bytes
  typedef logic [$clog2(BYTES_PER_WORD)-1:0] len_t;

  // transmit queue entry, 10 bits
  typedef struct packed {
    byte_t dat;   // byte to shift out
    logic  last;  // final byte of its command
    logic  rel;   // deselect slave after this byte
  } tx_entry_t;

  // receive queue entry, 9 bits
  typedef struct packed {
    byte_t dat;   // byte sampled from miso
    logic  last;  // closes the response word
  } rx_entry_t;

endpackage

// ==== source/spi_byte_queue.sv ====
/*
  Synchronous FIFO between pipeline stages, entry type set by parameter.
  QUEUE_DEPTH must be a power of two, 2 or more. No bypass, so a written
  entry shows at the output one cycle later.
*/

module spi_byte_queue #(
  parameter int  QUEUE_DEPTH = 4,           // entries, power of two
  parameter type entry_t     = logic [7:0]  // payload type
)(
  input  logic   clk,
  input  logic   rst_i,
  // write side
  input  logic   in_valid_i,
  input  entry_t in_entry_i,
  output logic   in_ready_o,
  // read side
  output logic   out_valid_o,
  output entry_t out_entry_o,
  input  logic   out_ready_i
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;  // count reaches QUEUE_DEPTH

  entry_t           mem_q [QUEUE_DEPTH];  // storage, no reset
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;                // occupancy
  logic             push;
  logic             pop;

  assign in_ready_o  = (cnt_q != CNT_W'(QUEUE_DEPTH));  // low when full
  assign out_valid_o = (cnt_q != '0);
  assign out_entry_o = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // none, or both at once
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem_q[wr_ptr_q] <= in_entry_i;
  end

endmodule

// ==== source/spi_cmd_unpack.sv ====
/*
  Command port with four-phase req/ack, split into bytes MSB first.
  A new command is latched only once the previous one is fully queued
  and ack has dropped, so a full transmit queue delays cmd_ack_o.
*/

module spi_cmd_unpack (
  input  logic                      clk,
  input  logic                      rst_i,
  // command port, four-phase
  input  logic                      cmd_req_i,
  input  spi_master_pkg::word_t     cmd_dat_i,
  input  spi_master_pkg::len_t      cmd_len_i,
  input  logic                      cmd_hold_i,  // keep slave selected after
  output logic                      cmd_ack_o,
  // transmit queue side
  output logic                      tx_valid_o,
  output spi_master_pkg::tx_entry_t tx_entry_o,
  input  logic                      tx_ready_i
);

  // latched word, seen as bytes so index 0 is the low byte
  spi_master_pkg::byte_t [spi_master_pkg::BYTES_PER_WORD-1:0] bytes_q;

  logic                 hold_q;  // copy of cmd_hold_i
  logic                 ack_q;
  logic                 busy_q;  // bytes still to emit
  spi_master_pkg::len_t idx_q;   // byte now offered, counts down
  logic                 take;    // latch a new command
  logic                 emit;    // byte accepted by queue

  assign take = cmd_req_i && !ack_q && !busy_q;
  assign emit = tx_valid_o && tx_ready_i;

  assign cmd_ack_o  = ack_q;
  assign tx_valid_o = busy_q;

  always_comb begin
    tx_entry_o.dat  = bytes_q[idx_q];
    tx_entry_o.last = (idx_q == '0);            // byte 0 closes the command
    tx_entry_o.rel  = (idx_q == '0) && !hold_q;  // deselect unless held
  end

  ////////////////////////////////////////////////////////////
  // handshake and byte walk
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      if (take) begin
        ack_q  <= 1'b1;
        busy_q <= 1'b1;
        idx_q  <= cmd_len_i;  // start at the top selected byte
      end else begin
        if (ack_q && !cmd_req_i) ack_q <= 1'b0;  // phase 4
        if (emit) begin
          if (idx_q == '0) begin
            busy_q <= 1'b0;  // last byte gone
          end else begin
            idx_q <= idx_q - 1'b1;
          end
        end
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (take) begin
      bytes_q <= cmd_dat_i;
      hold_q  <= cmd_hold_i;
    end
  end

endmodule

// ==== source/spi_shifter.sv ====
/*
  Mode 0 serializer: sclk idles low, mosi moves on falling edges, miso is
  sampled as sclk rises. One byte takes 16*CLK_DIV cycles, CLK_DIV >= 1.
  A byte starts only when the receive queue has room for its result.
*/

module spi_shifter #(
  parameter int CLK_DIV = 4  // clk cycles per sclk half period
)(
  input  logic                      clk,
  input  logic                      rst_i,
  // transmit queue side
  input  logic                      tx_valid_i,
  input  spi_master_pkg::tx_entry_t tx_entry_i,
  output logic                      tx_ready_o,
  // receive queue side
  output logic                      rx_valid_o,
  output spi_master_pkg::rx_entry_t rx_entry_o,
  input  logic                      rx_ready_i,
  // SPI pins
  output logic                      sclk_o,
  output logic                      ss_n_o,
  output logic                      mosi_o,
  input  logic                      miso_i
);

  localparam int               DIV_W   = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_TOP = DIV_W'(CLK_DIV - 1);

  // select setup is the first low half period of SHIFT
  typedef enum logic [1:0] {
    ST_IDLE,   // deselected
    ST_SHIFT,  // clocking a byte
    ST_PAUSE,  // selected, waiting for data or room
    ST_HOLD    // deselect hold after a release byte
  } state_t;

  state_t           state_q;
  logic [DIV_W-1:0] div_q;     // half period counter
  logic [2:0]       bit_q;     // bit within byte
  logic             sclk_q;
  logic             ss_n_q;
  logic             mosi_q;
  logic [6:0]       tx_sh_q;   // bits still to send
  logic [6:0]       rx_sh_q;   // bits sampled so far
  logic             last_q;    // flags of the byte in flight
  logic             rel_q;

  logic half_end;  // end of a half period
  logic rise;      // sclk goes high now
  logic fall;      // sclk goes low now
  logic byte_end;
  logic can_load;
  logic load;

  assign half_end = (state_q == ST_SHIFT) && (div_q == '0);
  assign rise     = half_end && !sclk_q;
  assign fall     = half_end && sclk_q;
  assign byte_end = fall && (bit_q == 3'd7);

  // next byte starts at once after the last falling edge, no gap
  assign can_load   = (state_q == ST_IDLE) || (state_q == ST_PAUSE) ||
                      (byte_end && !rel_q);
  assign tx_ready_o = can_load && rx_ready_i;
  assign load       = tx_ready_o && tx_valid_i;

  // push with the eighth sample, room was checked at load
  assign rx_valid_o = rise && (bit_q == 3'd7);

  always_comb begin
    rx_entry_o.dat  = {rx_sh_q, miso_i};
    rx_entry_o.last = last_q;
  end

  assign sclk_o = sclk_q;
  assign ss_n_o = ss_n_q;
  assign mosi_o = mosi_q;

  ////////////////////////////////////////////////////////////
  // control FSM and divider
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      sclk_q  <= 1'b0;
      ss_n_q  <= 1'b1;
      mosi_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE, ST_PAUSE: begin
          if (load) begin
            state_q <= ST_SHIFT;
            ss_n_q  <= 1'b0;                // select, setup time starts
            div_q   <= DIV_TOP;
            bit_q   <= '0;
            mosi_q  <= tx_entry_i.dat[7];  // MSB first
          end
        end
        ST_SHIFT: begin
          if (div_q != '0) begin
            div_q <= div_q - 1'b1;
          end else begin
            div_q  <= DIV_TOP;
            sclk_q <= ~sclk_q;
            if (sclk_q) begin  // falling edge
              if (bit_q != 3'd7) begin
                bit_q  <= bit_q + 3'd1;
                mosi_q <= tx_sh_q[6];
              end else if (rel_q) begin
                state_q <= ST_HOLD;
              end else if (load) begin
                bit_q  <= '0;  // back to back byte
                mosi_q <= tx_entry_i.dat[7];
              end else begin
                state_q <= ST_PAUSE;  // ss_n stays low
              end
            end
          end
        end
        ST_HOLD: begin
          if (div_q != '0) begin
            div_q <= div_q - 1'b1;
          end else begin
            state_q <= ST_IDLE;
            ss_n_q  <= 1'b1;
            mosi_q  <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      tx_sh_q <= tx_entry_i.dat[6:0];
      last_q  <= tx_entry_i.last;
      rel_q   <= tx_entry_i.rel;
    end else if (fall) begin
      tx_sh_q <= {tx_sh_q[5:0], 1'b0};
    end
    if (rise) rx_sh_q <= {rx_sh_q[5:0], miso_i};  // sample on rising sclk
  end

endmodule

// ==== source/spi_rsp_pack.sv ====
/*
  Packs received bytes into a word, first byte highest, upper bytes zero.
  The word goes out on a four-phase req/ack port; no byte is taken until
  the handshake has fully returned to idle.
*/

module spi_rsp_pack (
  input  logic                      clk,
  input  logic                      rst_i,
  // receive queue side
  input  logic                      rx_valid_i,
  input  spi_master_pkg::rx_entry_t rx_entry_i,
  output logic                      rx_ready_o,
  // response port, four-phase
  output logic                      rsp_req_o,
  output spi_master_pkg::word_t     rsp_dat_o,
  input  logic                      rsp_ack_i
);

  localparam int WORD_W = $bits(spi_master_pkg::word_t);
  localparam int BYTE_W = $bits(spi_master_pkg::byte_t);

  typedef enum logic [1:0] {
    ST_COLLECT,  // taking bytes
    ST_REQ,      // req high, waiting for ack
    ST_RELEASE   // req low, waiting for ack to drop
  } state_t;

  state_t                state_q;
  spi_master_pkg::word_t acc_q;     // word under construction
  spi_master_pkg::word_t acc_next;

  // older bytes move up by one byte position
  assign acc_next = {acc_q[WORD_W-BYTE_W-1:0], rx_entry_i.dat};

  assign rx_ready_o = (state_q == ST_COLLECT);
  assign rsp_req_o  = (state_q == ST_REQ);
  assign rsp_dat_o  = acc_q;  // frozen while req is high

  ////////////////////////////////////////////////////////////
  // collect and handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_COLLECT;
      acc_q   <= '0;
    end else begin
      case (state_q)
        ST_COLLECT: begin
          if (rx_valid_i) begin
            acc_q <= acc_next;
            if (rx_entry_i.last) state_q <= ST_REQ;  // req next cycle
          end
        end
        ST_REQ: begin
          if (rsp_ack_i) state_q <= ST_RELEASE;  // drop req
        end
        ST_RELEASE: begin
          if (!rsp_ack_i) begin
            state_q <= ST_COLLECT;
            acc_q   <= '0;  // fresh word per command
          end
        end
        default: state_q <= ST_COLLECT;
      endcase
    end
  end

endmodule

// ==== source/spi_master.sv ====
/*
  Single clock SPI master, mode 0, one slave select.
  Commands and responses use four-phase req/ack, stages use valid/ready.
  Several commands may be in flight, responses come back in order.
*/

module spi_master #(
  parameter int CLK_DIV     = 4,  // clk cycles per sclk half period
  parameter int QUEUE_DEPTH = 4   // entries per queue, power of two
)(
  input  logic                  clk,
  input  logic                  rst_i,
  // command port
  input  logic                  cmd_req_i,
  input  spi_master_pkg::word_t cmd_dat_i,
  input  spi_master_pkg::len_t  cmd_len_i,
  input  logic                  cmd_hold_i,
  output logic                  cmd_ack_o,
  // response port
  output logic                  rsp_req_o,
  output spi_master_pkg::word_t rsp_dat_o,
  input  logic                  rsp_ack_i,
  // SPI pins
  output logic                  sclk_o,
  output logic                  ss_n_o,
  output logic                  mosi_o,
  input  logic                  miso_i
);

  ////////////////////////////////////////////////////////////
  // stage links
  ////////////////////////////////////////////////////////////

  logic                      txw_valid, txr_valid;  // into / out of tx queue
  spi_master_pkg::tx_entry_t txw_entry, txr_entry;
  logic                      txw_ready, txr_ready;

  logic                      rxw_valid, rxr_valid;  // into / out of rx queue
  spi_master_pkg::rx_entry_t rxw_entry, rxr_entry;
  logic                      rxw_ready, rxr_ready;

  ////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////

  spi_cmd_unpack u_cmd_unpack (
    .clk        (clk),
    .rst_i      (rst_i),
    .cmd_req_i  (cmd_req_i),
    .cmd_dat_i  (cmd_dat_i),
    .cmd_len_i  (cmd_len_i),
    .cmd_hold_i (cmd_hold_i),
    .cmd_ack_o  (cmd_ack_o),
    .tx_valid_o (txw_valid),
    .tx_entry_o (txw_entry),
    .tx_ready_i (txw_ready)
  );

  spi_byte_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .entry_t     (spi_master_pkg::tx_entry_t)
  ) u_tx_queue (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (txw_valid),
    .in_entry_i  (txw_entry),
    .in_ready_o  (txw_ready),
    .out_valid_o (txr_valid),
    .out_entry_o (txr_entry),
    .out_ready_i (txr_ready)
  );

  spi_shifter #(
    .CLK_DIV (CLK_DIV)
  ) u_shifter (
    .clk        (clk),
    .rst_i      (rst_i),
    .tx_valid_i (txr_valid),
    .tx_entry_i (txr_entry),
    .tx_ready_o (txr_ready),
    .rx_valid_o (rxw_valid),
    .rx_entry_o (rxw_entry),
    .rx_ready_i (rxw_ready),
    .sclk_o     (sclk_o),
    .ss_n_o     (ss_n_o),
    .mosi_o     (mosi_o),
    .miso_i     (miso_i)
  );

  spi_byte_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .entry_t     (spi_master_pkg::rx_entry_t)
  ) u_rx_queue (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (rxw_valid),
    .in_entry_i  (rxw_entry),
    .in_ready_o  (rxw_ready),
    .out_valid_o (rxr_valid),
    .out_entry_o (rxr_entry),
    .out_ready_i (rxr_ready)
  );

  spi_rsp_pack u_rsp_pack (
    .clk        (clk),
    .rst_i      (rst_i),
    .rx_valid_i (rxr_valid),
    .rx_entry_i (rxr_entry),
    .rx_ready_o (rxr_ready),
    .rsp_req_o  (rsp_req_o),
    .rsp_dat_o  (rsp_dat_o),
    .rsp_ack_i  (rsp_ack_i)
  );

endmodule

// ==== bench/spi_master_properties.sv ====
/*
  Concurrent checks on the spi_master ports, bound into the top level.
  All checks are idle while rst_i is high.
*/

module spi_master_properties (
  input logic clk,
  input logic rst_i,
  input logic cmd_req_i,
  input logic cmd_ack_o,
  input logic rsp_req_o,
  input logic rsp_ack_i,
  input logic sclk_o,
  input logic ss_n_o,
  input logic mosi_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
    $rose(cmd_ack_o) |-> $past(cmd_req_i))
    else $error("cmd_ack_o rose while cmd_req_i was low");

  // response req held until acknowledged
  req_holds: assert property (@(posedge clk) disable iff (rst_i)
    rsp_req_o && !rsp_ack_i |=> rsp_req_o)
    else $error("rsp_req_o dropped before rsp_ack_i");

  sclk_idle_deselected: assert property (@(posedge clk) disable iff (rst_i)
    ss_n_o |-> !sclk_o)
    else $error("sclk_o high while ss_n_o deasserted");

  // mode 0, mosi only moves in the low phase
  mosi_stable_high: assert property (@(posedge clk) disable iff (rst_i)
    sclk_o |-> $stable(mosi_o))
    else $error("mosi_o changed while sclk_o high");

endmodule

bind spi_master spi_master_properties u_props (
  .clk       (clk),
  .rst_i     (rst_i),
  .cmd_req_i (cmd_req_i),
  .cmd_ack_o (cmd_ack_o),
  .rsp_req_o (rsp_req_o),
  .rsp_ack_i (rsp_ack_i),
  .sclk_o    (sclk_o),
  .ss_n_o    (ss_n_o),
  .mosi_o    (mosi_o)
);

// ==== bench/spi_master_clkgen.sv ====
/*
  Free running 40 ns clock, reset high for the first 10 cycles.
  Reset is released on a falling edge.
*/

module spi_master_clkgen (
  output logic clk_o,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 20;  // ns
  localparam int RST_CYCLES  = 10;

  always #HALF_PERIOD clk_o = ~clk_o;

  initial begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;  // inputs move on falling edges
  end

endmodule

// ==== bench/spi_master_tb.sv ====
/*
  Testbench for spi_master with CLK_DIV 2 and QUEUE_DEPTH 4.
  Commands from the table go out back to back; the slave model loops
  mosi to miso, inverted per row. The last row must not set hold.
*/

module spi_master_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_DIV     = 2;
  localparam int QUEUE_DEPTH = 4;
  localparam int ROWS        = 16;
  localparam int TIMEOUT     = 2 * ROWS * (64 * CLK_DIV + 64);  // cycles

  logic                  clk;
  logic                  rst_i;
  logic                  cmd_req_i;
  spi_master_pkg::word_t cmd_dat_i;
  spi_master_pkg::len_t  cmd_len_i;
  logic                  cmd_hold_i;
  logic                  cmd_ack_o;
  logic                  rsp_req_o;
  spi_master_pkg::word_t rsp_dat_o;
  logic                  rsp_ack_i;
  logic                  sclk_o;
  logic                  ss_n_o;
  logic                  mosi_o;
  logic                  miso_i;

  // stimulus table, one row per command
  spi_master_pkg::word_t tbl_dat  [ROWS];
  spi_master_pkg::len_t  tbl_len  [ROWS];
  logic                  tbl_hold [ROWS];
  logic                  tbl_inv  [ROWS];
  int                    tbl_dly  [ROWS];  // cycles before rsp_ack_i
  spi_master_pkg::word_t tbl_exp  [ROWS];
  int                    row_cnt = 0;

  logic   inv_byte [4*ROWS];       // invert flag per byte, send order
  int     total_bytes = 0;
  integer seed        = 32'h7ec8_4661;
  int     err_cnt     = 0;
  int     pass_cnt    = 0;
  int     fail_cnt    = 0;
  int     cycle_cnt   = 0;
  int     all_edges   = 0;         // rising sclk while selected
  int     seg_edges   = 0;         // same, since last deselect
  int     rel_cursor  = 0;         // first row not yet deselected
  logic   sclk_prev   = 1'b0;
  logic   ss_prev     = 1'b1;

  spi_master_clkgen u_clkgen (
    .clk_o (clk),
    .rst_o (rst_i)
  );

  spi_master #(
    .CLK_DIV     (CLK_DIV),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_spi_master (
    .clk        (clk),
    .rst_i      (rst_i),
    .cmd_req_i  (cmd_req_i),
    .cmd_dat_i  (cmd_dat_i),
    .cmd_len_i  (cmd_len_i),
    .cmd_hold_i (cmd_hold_i),
    .cmd_ack_o  (cmd_ack_o),
    .rsp_req_o  (rsp_req_o),
    .rsp_dat_o  (rsp_dat_o),
    .rsp_ack_i  (rsp_ack_i),
    .sclk_o     (sclk_o),
    .ss_n_o     (ss_n_o),
    .mosi_o     (mosi_o),
    .miso_i     (miso_i)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] t=%0d ns %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string what, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", what);
    end else begin
      fail_cnt++;
      $display("test %s: failed", what);
    end
  endtask

  task automatic add_row(input spi_master_pkg::word_t dat, input spi_master_pkg::len_t len,
                         input logic hold, input logic inv, input logic rnd_dly,
                         input spi_master_pkg::word_t exp);
    tbl_dat[row_cnt]  = dat;
    tbl_len[row_cnt]  = len;
    tbl_hold[row_cnt] = hold;
    tbl_inv[row_cnt]  = inv;
    tbl_dly[row_cnt]  = rnd_dly ? 160 + int'($unsigned($random(seed)) % 96) : 0;
    tbl_exp[row_cnt]  = exp;
    row_cnt++;
  endtask

  task automatic fill_table();
    int k;
    //      data           len   hold  inv   rnd   expected
    add_row(32'h0000_00a5, 2'd0, 1'b0, 1'b0, 1'b0, 32'h0000_00a5);
    add_row(32'h1234_5678, 2'd1, 1'b0, 1'b0, 1'b0, 32'h0000_5678);
    add_row(32'hdead_beef, 2'd2, 1'b0, 1'b0, 1'b0, 32'h00ad_beef);
    add_row(32'hcafe_f00d, 2'd3, 1'b0, 1'b0, 1'b0, 32'hcafe_f00d);
    add_row(32'h0000_003c, 2'd0, 1'b0, 1'b1, 1'b0, 32'h0000_00c3);  // inverted miso
    add_row(32'hff00_a55a, 2'd3, 1'b0, 1'b1, 1'b0, 32'h00ff_5aa5);
    add_row(32'h7777_1234, 2'd1, 1'b0, 1'b1, 1'b0, 32'h0000_edcb);
    add_row(32'h0000_0011, 2'd0, 1'b1, 1'b0, 1'b0, 32'h0000_0011);  // hold chain
    add_row(32'h0000_2233, 2'd1, 1'b1, 1'b1, 1'b0, 32'h0000_ddcc);
    add_row(32'h0044_5566, 2'd2, 1'b0, 1'b0, 1'b0, 32'h0044_5566);
    add_row(32'h89ab_cdef, 2'd3, 1'b0, 1'b0, 1'b1, 32'h89ab_cdef);  // back-pressure
    add_row(32'h0102_0304, 2'd2, 1'b0, 1'b0, 1'b1, 32'h0002_0304);
    add_row(32'h5555_aaaa, 2'd1, 1'b0, 1'b1, 1'b1, 32'h0000_5555);
    add_row(32'h0f0f_0f0f, 2'd3, 1'b1, 1'b0, 1'b1, 32'h0f0f_0f0f);
    add_row(32'hb0b1_b2b3, 2'd0, 1'b0, 1'b0, 1'b1, 32'h0000_00b3);
    add_row(32'h6000_0001, 2'd3, 1'b0, 1'b1, 1'b1, 32'h9fff_fffe);
    for (int i = 0; i < 4*ROWS; i++) inv_byte[i] = 1'b0;
    k = 0;
    for (int r = 0; r < ROWS; r++) begin
      for (int b = 0; b <= int'(tbl_len[r]); b++) begin
        inv_byte[k] = tbl_inv[r];
        k++;
      end
    end
    total_bytes = k;
  endtask

  // four-phase command, one row
  task automatic send_cmd(input int r);
    @(negedge clk);
    cmd_dat_i  = tbl_dat[r];
    cmd_len_i  = tbl_len[r];
    cmd_hold_i = tbl_hold[r];
    cmd_req_i  = 1'b1;
    @(negedge clk);
    while (!cmd_ack_o) @(negedge clk);
    cmd_req_i = 1'b0;
    @(negedge clk);
    while (cmd_ack_o) @(negedge clk);  // back to idle
  endtask

  task automatic take_rsp(input int r);
    int errs_before;
    errs_before = err_cnt;
    @(negedge clk);
    while (!rsp_req_o) @(negedge clk);
    compare("rsp_dat_o", tbl_exp[r], rsp_dat_o);
    repeat (tbl_dly[r]) @(negedge clk);
    compare("rsp_dat_o at ack", tbl_exp[r], rsp_dat_o);  // held while req high
    rsp_ack_i = 1'b1;
    @(negedge clk);
    while (rsp_req_o) @(negedge clk);
    rsp_ack_i = 1'b0;
    report_test($sformatf("row %0d, %0d byte(s), hold %0d, inv %0d, ack delay %0d",
                          r, int'(tbl_len[r]) + 1, tbl_hold[r], tbl_inv[r], tbl_dly[r]),
                errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // slave model, sclk bookkeeping, timeout
  ////////////////////////////////////////////////////////////

  // sampled at posedge, values from before the edge
  always @(posedge clk) begin
    int   exp_bytes;
    logic more;
    if (!rst_i) begin
      if (sclk_o && !sclk_prev && !ss_n_o) begin
        all_edges++;
        seg_edges++;
      end
      if (ss_n_o) compare("sclk_o", 32'd0, {31'd0, sclk_o});  // idle while deselected
      if (ss_n_o && !ss_prev) begin
        if (rel_cursor >= ROWS) begin
          err_cnt++;
          $display("[ERROR] t=%0d ns slave deselected more often than commands sent", $time);
        end else begin
          exp_bytes = 0;
          do begin
            exp_bytes += int'(tbl_len[rel_cursor]) + 1;
            more = tbl_hold[rel_cursor];
            rel_cursor++;
          end while (more && rel_cursor < ROWS);
          compare("sclk edges per select", 32'(8 * exp_bytes), 32'(seg_edges));
        end
        seg_edges = 0;
      end
    end
    sclk_prev = sclk_o;
    ss_prev   = ss_n_o;
  end

  // loopback, byte index from edge count
  always @(negedge clk) begin
    miso_i <= mosi_o ^ inv_byte[all_edges / 8];
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      $display("run timed out after %0d cycles, a handshake never completed", cycle_cnt);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int errs;
    cmd_req_i  = 1'b0;
    cmd_dat_i  = '0;
    cmd_len_i  = '0;
    cmd_hold_i = 1'b0;
    rsp_ack_i  = 1'b0;
    miso_i     = 1'b0;
    fill_table();
    @(negedge clk);
    while (rst_i) @(negedge clk);

    errs = err_cnt;
    compare("cmd_ack_o", 32'd0, {31'd0, cmd_ack_o});
    compare("rsp_req_o", 32'd0, {31'd0, rsp_req_o});
    compare("sclk_o", 32'd0, {31'd0, sclk_o});
    compare("mosi_o", 32'd0, {31'd0, mosi_o});
    compare("ss_n_o", 32'd1, {31'd0, ss_n_o});
    report_test("after reset", errs);

    // commands and responses run independently
    fork
      for (int r = 0; r < ROWS; r++) send_cmd(r);
      for (int r = 0; r < ROWS; r++) take_rsp(r);
    join

    errs = err_cnt;
    while (!ss_n_o) @(negedge clk);
    repeat (2) @(negedge clk);  // let the monitor see the last deselect
    compare("deselected rows", 32'(ROWS), 32'(rel_cursor));
    compare("total sclk edges", 32'(8 * total_bytes), 32'(all_edges));
    report_test("sclk count and release", errs);

    $display("%0d tests, %0d ok, %0d failed, %0d mismatches",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== spi_master.f ====
source/spi_master_pkg.sv
source/spi_byte_queue.sv
source/spi_cmd_unpack.sv
source/spi_shifter.sv
source/spi_rsp_pack.sv
source/spi_master.sv
bench/spi_master_properties.sv
bench/spi_master_clkgen.sv
bench/spi_master_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the SPI master testbench with Verilator, run it, judge the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=spi_master_tb

rm -rf "${BUILD_DIR}"

verilator --binary --timing --assert -Wno-fatal \
  --top-module "${TOP}" -Mdir "${BUILD_DIR}" -f spi_master.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./${BUILD_DIR}/V${TOP}" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
  echo "simulation exited with status ${sim_status}"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "${LOG_FILE}"; then
  exit 0
fi
exit 1
